//--- list.f
common/arm_pkg.sv
logic/insn_queue.sv
issue/use_def_decode.sv
issue/cond_check.sv
issue/issue_stage.sv
logic/issue_pipe.sv
dv/issue_pipe_tb.sv

//--- Bender.yml
package:
  name: issue_pipe

sources:
  - common/arm_pkg.sv
  - logic/insn_queue.sv
  - issue/use_def_decode.sv
  - issue/cond_check.sv
  - issue/issue_stage.sv
  - logic/issue_pipe.sv
  - target: test
    files:
      - dv/issue_pipe_tb.sv

//--- dv/issue_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_pipe_tb import arm_pkg::*; ();

	localparam int queue_depth = 4;
	localparam int clk_period = 40;
	localparam int reset_cycles = 16;
	localparam int wait_limit = 64; // Cycles for one sequence to issue.
	localparam int drain_cycles = 4;
	localparam int num_runs = 10;
	localparam int max_entries = 8;
	localparam int cycle_budget = reset_cycles + 20 +
		num_runs * (max_entries * 4 + wait_limit + drain_cycles);

	logic clk;
	logic rst;
	logic in_valid;
	fetch_t in_entry;
	logic in_ready;
	word_t cpsr;
	issued_t out;

	fetch_t seq_q[$]; // Entries pushed into the DUT.
	fetch_t exp_q[$]; // Entries expected to issue, in order.
	int gap_q[$]; // Bubbles between consecutive issued entries.
	issued_t out_log[$];
	logic logging;
	logic saw_full;
	logic [31:0] rng_state;
	int errors;
	int pass_count;
	int fail_count;

	issue_pipe #(
		.queue_depth(queue_depth)
	) dut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_entry(in_entry),
		.in_ready(in_ready),
		.cpsr(cpsr),
		.out(out)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// Output is stable at the falling edge.
	always @(negedge clk)
	begin
		if (logging)
			out_log.push_back(out);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Data processing, register operand with LSL #1.
	function automatic word_t alu_reg(input cond_t cond, input logic [3:0] op, input logic s,
		input reg_idx_t rn, input reg_idx_t rd, input reg_idx_t rm);
		return {cond, 3'b000, op, s, rn, rd, 5'd1, 2'b00, 1'b0, rm};
	endfunction

	function automatic word_t branch(input cond_t cond);
		return {cond, 4'b1010, 24'h000010};
	endfunction

	// LDMIA without writeback.
	function automatic word_t ldm(input reg_idx_t rn, input logic [15:0] list);
		return {cond_al, 3'b100, 5'b01001, rn, list};
	endfunction

	function automatic int count_real();
		int n;
		n = 0;
		foreach (out_log[i])
			if (!out_log[i].bubble)
				n++;
		return n;
	endfunction

	task automatic clear_seq();
		seq_q.delete();
		exp_q.delete();
		gap_q.delete();
	endtask

	task automatic queue_insn(input word_t insn, input logic issues);
		fetch_t e;
		e.insn = insn;
		e.pc = next_rand() & 32'hffff_fffc; // Word aligned.
		seq_q.push_back(e);
		if (issues)
			exp_q.push_back(e);
	endtask

	// One entry per cycle, held while in_ready is low.
	task automatic push_all();
		int i;
		i = 0;
		while (i < seq_q.size())
		begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_entry <= seq_q[i];
			@(negedge clk);
			if (in_ready)
				i++;
			else
				saw_full = 1'b1;
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic run_sequence();
		int waited;
		int k;
		int pos[$];
		out_log.delete();
		logging = 1'b1;
		push_all();
		waited = 0;
		while ((count_real() < exp_q.size()) && (waited < wait_limit))
		begin
			@(posedge clk);
			waited++;
		end
		if (count_real() < exp_q.size())
		begin
			$display("Timed out at %0t waiting for %0d issued instructions, saw %0d",
				$time, exp_q.size(), count_real());
			errors++;
		end
		repeat (drain_cycles) @(posedge clk); // Anything extra shows up here.
		logging = 1'b0;
		foreach (out_log[i])
			if (!out_log[i].bubble)
				pos.push_back(i);
		assert (pos.size() == exp_q.size())
		else
		begin
			$display("Mismatch at %0t: %0d instructions issued, expected %0d",
				$time, pos.size(), exp_q.size());
			errors++;
		end
		for (k = 0; (k < pos.size()) && (k < exp_q.size()); k++)
		begin
			assert ((out_log[pos[k]].insn == exp_q[k].insn) && (out_log[pos[k]].pc == exp_q[k].pc))
			else
			begin
				$display("Mismatch at %0t: issue %0d is %h at pc %h, expected %h at pc %h", $time,
					k, out_log[pos[k]].insn, out_log[pos[k]].pc, exp_q[k].insn, exp_q[k].pc);
				errors++;
			end
		end
		for (k = 0; (k < gap_q.size()) && (k + 1 < pos.size()); k++)
		begin
			assert (pos[k + 1] - pos[k] - 1 == gap_q[k])
			else
			begin
				$display("Mismatch at %0t: %0d bubbles after issue %0d, expected %0d",
					$time, pos[k + 1] - pos[k] - 1, k, gap_q[k]);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before)
		begin
			pass_count++;
			$display("%s: pass", name);
		end
		else
		begin
			fail_count++;
			$display("%s: FAIL with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_reset();
		int errs_before;
		errs_before = errors;
		@(negedge clk);
		assert (out.bubble === 1'b1)
		else
		begin
			$display("Mismatch at %0t: output bubble is %b after reset", $time, out.bubble);
			errors++;
		end
		assert (in_ready === 1'b1)
		else
		begin
			$display("Mismatch at %0t: in_ready is %b after reset", $time, in_ready);
			errors++;
		end
		finish_test("reset state", errs_before);
	endtask

	task automatic test_independent();
		int errs_before;
		int regs[15];
		int i;
		int j;
		int tmp;
		logic [3:0] ops[4];
		errs_before = errors;
		ops = '{alu_add, alu_sub, alu_eor, alu_orr};
		for (i = 0; i < 15; i++)
			regs[i] = i;
		for (i = 14; i > 0; i--)
		begin
			j = int'(next_rand() % (i + 1)); // Shuffle so no register repeats.
			tmp = regs[i];
			regs[i] = regs[j];
			regs[j] = tmp;
		end
		clear_seq();
		for (i = 0; i < 4; i++)
		begin
			queue_insn(alu_reg(cond_al, ops[next_rand() % 4], 1'b0, reg_idx_t'(regs[3 * i]),
				reg_idx_t'(regs[3 * i + 1]), reg_idx_t'(regs[3 * i + 2])), 1'b1);
			if (i > 0)
				gap_q.push_back(0);
		end
		run_sequence();
		finish_test("independent ALU stream", errs_before);
	endtask

	task automatic test_dependency();
		int errs_before;
		errs_before = errors;
		clear_seq();
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 2, 1, 3), 1'b1); // r1 = r2 + r3.
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 1, 4, 5), 1'b1);
		gap_q.push_back(2);
		run_sequence();
		clear_seq();
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 2, 1, 3), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 7, 6, 8), 1'b1); // Unrelated.
		gap_q.push_back(0);
		run_sequence();
		finish_test("register dependency", errs_before);
	endtask

	task automatic test_cond_fail();
		int errs_before;
		errs_before = errors;
		@(posedge clk);
		cpsr <= 32'h0000_0000; // Z clear, so EQ fails.
		clear_seq();
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 6, 5, 7), 1'b1);
		queue_insn(alu_reg(cond_eq, alu_add, 1'b0, 3, 2, 4), 1'b0);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 2, 8, 9), 1'b1);
		gap_q.push_back(1); // Only the slot of the dropped instruction.
		run_sequence();
		finish_test("failed condition", errs_before);
	endtask

	task automatic test_cpsr_ldm();
		int errs_before;
		errs_before = errors;
		@(posedge clk);
		cpsr <= 32'h4000_0000; // Z set, so EQ passes.
		clear_seq();
		queue_insn(alu_reg(cond_al, alu_add, 1'b1, 7, 6, 8), 1'b1);
		queue_insn(branch(cond_eq), 1'b1);
		gap_q.push_back(2);
		run_sequence();
		clear_seq();
		queue_insn(alu_reg(cond_al, alu_add, 1'b1, 7, 6, 8), 1'b1);
		queue_insn(branch(cond_al), 1'b1);
		gap_q.push_back(0);
		run_sequence();
		clear_seq();
		queue_insn(ldm(8, 16'h0600), 1'b1); // Loads r9 and r10.
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 10, 11, 12), 1'b1);
		gap_q.push_back(2);
		run_sequence();
		clear_seq();
		queue_insn(ldm(8, 16'h0600), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 12, 11, 9), 1'b1);
		gap_q.push_back(2);
		run_sequence();
		finish_test("CPSR and LDM hazards", errs_before);
	endtask

	task automatic test_backpressure();
		int errs_before;
		errs_before = errors;
		saw_full = 1'b0;
		clear_seq();
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 2, 1, 3), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 1, 4, 5), 1'b1); // Chain of readers.
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 4, 6, 7), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 6, 8, 9), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 8, 10, 11), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 13, 12, 14), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 13, 0, 14), 1'b1);
		queue_insn(alu_reg(cond_al, alu_add, 1'b0, 5, 3, 7), 1'b1);
		gap_q = '{2, 2, 2, 2, 0, 0, 0};
		run_sequence();
		assert (saw_full)
		else
		begin
			$display("in_ready never went low while issue was stalled (at %0t)", $time);
			errors++;
		end
		finish_test("back-pressure", errs_before);
	endtask

	initial
	begin
		#(cycle_budget * clk_period);
		$display("Watchdog expired after %0d cycles, the run did not finish", cycle_budget);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_entry = '0;
		cpsr = '0;
		logging = 1'b0;
		saw_full = 1'b0;
		rng_state = 32'd82651;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_independent();
		test_dependency();
		test_cond_fail();
		test_cpsr_ldm();
		test_backpressure();
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/issue_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module issue_pipe import arm_pkg::*; #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fetch_t in_entry,
	output logic in_ready,
	input word_t cpsr,
	output issued_t out
);

	fetch_t head;
	logic head_bubble;
	logic stall;

	insn_queue #(
		.queue_depth(queue_depth)
	) u_queue (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_entry(in_entry),
		.in_ready(in_ready),
		.stall(stall),
		.head(head),
		.head_bubble(head_bubble)
	);

	// Stall goes back to the queue in the same cycle.
	issue_stage u_issue (
		.clk(clk),
		.rst(rst),
		.head(head),
		.head_bubble(head_bubble),
		.cpsr(cpsr),
		.stall(stall),
		.out(out)
	);

endmodule

`default_nettype wire

//--- issue/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage import arm_pkg::*; (
	input logic clk,
	input logic rst,
	input fetch_t head,
	input logic head_bubble,
	input word_t cpsr,
	output logic stall,
	output issued_t out
);

	// What an in-flight instruction will write.
	typedef struct packed {
		logic cpsr;
		reg_mask_t regs;
	} resv_t;

	use_def_t ud;
	logic met;
	logic waiting_cpsr;
	logic waiting_regs;
	logic waiting;
	logic issue_ok;

	resv_t ex_slot;
	resv_t mem_slot;

	logic out_bubble;
	word_t out_insn;
	word_t out_pc;

	use_def_decode u_decode (
		.insn(head.insn),
		.ud(ud)
	);

	cond_check u_cond (
		.cond(head.insn[31:28]),
		.cpsr(cpsr),
		.met(met)
	);

	// Writeback reaches the register file, so two slots are enough.
	assign waiting_cpsr = ud.use_cpsr && (ex_slot.cpsr || mem_slot.cpsr);
	assign waiting_regs = |(ud.use_regs & (ex_slot.regs | mem_slot.regs));
	assign waiting = waiting_cpsr || waiting_regs;

	assign stall = waiting && !head_bubble;
	assign issue_ok = !head_bubble && !waiting && met; // Failed condition reserves nothing.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_slot <= '0;
			mem_slot <= '0;
			out_bubble <= 1'b1;
		end
		else
		begin
			ex_slot <= issue_ok ? '{cpsr: ud.def_cpsr, regs: ud.def_regs} : '0;
			mem_slot <= ex_slot;
			out_bubble <= !issue_ok;
		end
	end

	always_ff @(posedge clk)
	begin
		out_insn <= head.insn;
		out_pc <= head.pc;
	end

	assign out = '{bubble: out_bubble, insn: out_insn, pc: out_pc};

	// A held head is still at the queue front on the next cycle.
	a_stall_holds_head: assert property (@(posedge clk) disable iff (rst)
		stall |=> !head_bubble && $stable(head));

endmodule

`default_nettype wire

//--- issue/cond_check.sv
`timescale 1ns/1ps
`default_nettype none

module cond_check import arm_pkg::*; (
	input cond_t cond,
	input word_t cpsr,
	output logic met
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = cpsr[cpsr_n];
	assign z = cpsr[cpsr_z];
	assign c = cpsr[cpsr_c];
	assign v = cpsr[cpsr_v];

	always_comb
	begin
		case (cond)
			cond_eq: met = z;
			cond_ne: met = !z;
			cond_cs: met = c;
			cond_cc: met = !c;
			cond_mi: met = n;
			cond_pl: met = !n;
			cond_vs: met = v;
			cond_vc: met = !v;
			cond_hi: met = c && !z; // Unsigned higher.
			cond_ls: met = !c || z;
			cond_ge: met = (n == v);
			cond_lt: met = (n != v);
			cond_gt: met = !z && (n == v);
			cond_le: met = z || (n != v);
			cond_al: met = 1'b1;
			cond_nv: met = 1'b0;
			default: met = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- issue/use_def_decode.sv
`timescale 1ns/1ps
`default_nettype none

module use_def_decode import arm_pkg::*; (
	input word_t insn,
	output use_def_t ud
);

	localparam logic [1:0] shift_lsl = 2'b00;
	localparam logic [1:0] shift_ror = 2'b11;

	reg_idx_t rn;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rm;
	reg_idx_t rd_mul;
	reg_idx_t rn_mul;
	cond_t cond;
	logic [3:0] alu_opc;
	logic cond_matters;
	logic shift_carry;

	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	assign rd_mul = insn[19:16]; // Multiply swaps the Rd and Rn fields.
	assign rn_mul = insn[15:12];
	assign cond = insn[31:28];
	assign alu_opc = insn[24:21];
	assign cond_matters = (cond != cond_al);

	// Carry in reaches the shifter for register shifts, LSL #0 and RRX.
	assign shift_carry = !insn[25] && (insn[4] ||
		(((insn[6:5] == shift_lsl) || (insn[6:5] == shift_ror)) && (insn[11:7] == '0)));

	function automatic reg_mask_t idxbit(input reg_idx_t r);
		return (r == 4'd15) ? '0 : reg_mask_t'(1) << r;
	endfunction

	function automatic logic alu_is_logical(input logic [3:0] op);
		case (op)
			alu_and, alu_eor, alu_tst, alu_teq, alu_orr, alu_mov, alu_bic, alu_mvn: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic alu_flags_only(input logic [3:0] op);
		case (op)
			alu_tst, alu_teq, alu_cmp, alu_cmn: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	always_comb
	begin
		ud = '0;
		ud.use_cpsr = cond_matters;
		casez (insn)
			dec_mult:
			begin
				ud.use_regs = (insn[21] ? idxbit(rn_mul) : '0) | idxbit(rs) | idxbit(rm);
				ud.def_cpsr = insn[20];
				ud.def_regs = idxbit(rd_mul);
			end
			dec_mrs:
			begin
				ud.use_cpsr = cond_matters || !insn[22]; // Reads CPSR, not SPSR.
				ud.def_regs = idxbit(rd);
			end
			dec_msr:
			begin
				ud.use_regs = idxbit(rm);
				ud.def_cpsr = 1'b1;
			end
			dec_msr_flags:
			begin
				ud.use_regs = insn[25] ? '0 : idxbit(rm);
				ud.def_cpsr = 1'b1;
			end
			dec_swp:
			begin
				ud.use_regs = idxbit(rn) | idxbit(rm);
				ud.def_regs = idxbit(rd);
			end
			dec_bx:
				ud.use_regs = idxbit(rm);
			dec_hdata_reg, dec_hdata_imm:
			begin
				ud.use_regs = idxbit(rn) | (insn[20] ? '0 : idxbit(rd));
				if (!insn[22])
					ud.use_regs = ud.use_regs | idxbit(rm); // Register offset.
				ud.def_regs = insn[20] ? idxbit(rd) : '0;
			end
			dec_alu:
			begin
				ud.use_cpsr = cond_matters || shift_carry ||
					(alu_opc == alu_adc) || (alu_opc == alu_sbc) || (alu_opc == alu_rsc);
				ud.use_regs = insn[25] ? '0 : (insn[4] ? (idxbit(rs) | idxbit(rm)) : idxbit(rm));
				if ((alu_opc != alu_mov) && (alu_opc != alu_mvn))
					ud.use_regs = ud.use_regs | idxbit(rn);
				ud.def_cpsr = insn[20] || alu_is_logical(alu_opc);
				ud.def_regs = alu_flags_only(alu_opc) ? '0 : idxbit(rd);
			end
			dec_ldrstr_undef:
				ud.use_cpsr = 1'b0; // Traps, touches nothing.
			dec_ldrstr:
			begin
				ud.use_regs = idxbit(rn) | (insn[20] ? '0 : idxbit(rd));
				ud.def_regs = insn[20] ? idxbit(rd) : '0;
			end
			dec_ldmstm:
			begin
				ud.use_regs = idxbit(rn) | (insn[20] ? '0 : (insn[15:0] & 16'h7fff));
				ud.def_cpsr = insn[22]; // Covers the SPSR restore.
				ud.def_regs = (insn[21] ? idxbit(rn) : '0) |
					(insn[20] ? (insn[15:0] & 16'h7fff) : '0);
			end
			dec_ldcstc:
			begin
				ud.use_regs = idxbit(rn);
				ud.def_regs = insn[21] ? idxbit(rn) : '0;
			end
			dec_mrcmcr:
			begin
				ud.use_regs = insn[20] ? '0 : idxbit(rd);
				ud.def_regs = insn[20] ? idxbit(rd) : '0;
			end
			dec_branch, dec_cdp, dec_swi:
				ud.use_regs = '0; // Condition only.
			default:
				ud = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/insn_queue.sv
`timescale 1ns/1ps
`default_nettype none

module insn_queue import arm_pkg::*; #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fetch_t in_entry,
	output logic in_ready,
	input logic stall,
	output fetch_t head,
	output logic head_bubble
);

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [cnt_w-1:0] cnt_t;

	fetch_t mem [queue_depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic push;
	logic pop;

	// Wraps for depths that are not a power of two.
	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(queue_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = (count != cnt_t'(queue_depth));
	assign head_bubble = (count == '0);
	assign head = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = !head_bubble && !stall; // Head leaves unless issue holds it.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + cnt_t'(push) - cnt_t'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_entry;
	end

	// The count never passes the depth, so a full queue takes nothing in.
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		count <= cnt_t'(queue_depth));

endmodule

`default_nettype wire

//--- common/arm_pkg.sv
`default_nettype none

package arm_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [15:0] reg_mask_t; // Bit 15 stays clear, the PC is not tracked.
	typedef logic [3:0] cond_t;

	// Condition field values.
	localparam cond_t cond_eq = 4'h0;
	localparam cond_t cond_ne = 4'h1;
	localparam cond_t cond_cs = 4'h2;
	localparam cond_t cond_cc = 4'h3;
	localparam cond_t cond_mi = 4'h4;
	localparam cond_t cond_pl = 4'h5;
	localparam cond_t cond_vs = 4'h6;
	localparam cond_t cond_vc = 4'h7;
	localparam cond_t cond_hi = 4'h8;
	localparam cond_t cond_ls = 4'h9;
	localparam cond_t cond_ge = 4'ha;
	localparam cond_t cond_lt = 4'hb;
	localparam cond_t cond_gt = 4'hc;
	localparam cond_t cond_le = 4'hd;
	localparam cond_t cond_al = 4'he;
	localparam cond_t cond_nv = 4'hf;

	// Data processing opcodes, insn[24:21].
	localparam logic [3:0] alu_and = 4'h0;
	localparam logic [3:0] alu_eor = 4'h1;
	localparam logic [3:0] alu_sub = 4'h2;
	localparam logic [3:0] alu_rsb = 4'h3;
	localparam logic [3:0] alu_add = 4'h4;
	localparam logic [3:0] alu_adc = 4'h5;
	localparam logic [3:0] alu_sbc = 4'h6;
	localparam logic [3:0] alu_rsc = 4'h7;
	localparam logic [3:0] alu_tst = 4'h8;
	localparam logic [3:0] alu_teq = 4'h9;
	localparam logic [3:0] alu_cmp = 4'ha;
	localparam logic [3:0] alu_cmn = 4'hb;
	localparam logic [3:0] alu_orr = 4'hc;
	localparam logic [3:0] alu_mov = 4'hd;
	localparam logic [3:0] alu_bic = 4'he;
	localparam logic [3:0] alu_mvn = 4'hf;

	localparam int cpsr_n = 31;
	localparam int cpsr_z = 30;
	localparam int cpsr_c = 29;
	localparam int cpsr_v = 28;

	// Instruction classes, matched with casez in this order.
	localparam word_t dec_mult        = 32'b????_0000_00??_????_????_????_1001_????;
	localparam word_t dec_mrs         = 32'b????_0001_0?00_1111_????_0000_0000_0000;
	localparam word_t dec_msr         = 32'b????_0001_0?10_1001_1111_0000_0000_????;
	localparam word_t dec_msr_flags   = 32'b????_00?1_0?10_1000_1111_????_????_????;
	localparam word_t dec_swp         = 32'b????_0001_0?00_????_????_0000_1001_????;
	localparam word_t dec_bx          = 32'b????_0001_0010_1111_1111_1111_0001_????;
	localparam word_t dec_hdata_reg   = 32'b????_000?_?0??_????_????_0000_1??1_????;
	localparam word_t dec_hdata_imm   = 32'b????_000?_?1??_????_????_????_1??1_????;
	localparam word_t dec_alu         = 32'b????_00??_????_????_????_????_????_????;
	localparam word_t dec_ldrstr_undef = 32'b????_011?_????_????_????_????_???1_????;
	localparam word_t dec_ldrstr      = 32'b????_01??_????_????_????_????_????_????;
	localparam word_t dec_ldmstm      = 32'b????_100?_????_????_????_????_????_????;
	localparam word_t dec_branch      = 32'b????_101?_????_????_????_????_????_????;
	localparam word_t dec_ldcstc      = 32'b????_110?_????_????_????_????_????_????;
	localparam word_t dec_cdp         = 32'b????_1110_????_????_????_????_???0_????;
	localparam word_t dec_mrcmcr      = 32'b????_1110_????_????_????_????_???1_????;
	localparam word_t dec_swi         = 32'b????_1111_????_????_????_????_????_????;

	typedef struct packed {
		word_t insn;
		word_t pc;
	} fetch_t;

	typedef struct packed {
		logic bubble;
		word_t insn;
		word_t pc;
	} issued_t;

	typedef struct packed {
		logic use_cpsr;
		reg_mask_t use_regs;
		logic def_cpsr;
		reg_mask_t def_regs;
	} use_def_t;

endpackage

`default_nettype wire
